//--- common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // vector types with a meaning
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // data or address word
  typedef logic [3:0]  be_t;        // one enable bit per byte lane
  typedef logic [1:0]  byte_off_t;  // byte position inside a word
  typedef logic [1:0]  data_type_t; // access size code
  typedef logic [1:0]  sign_ext_t;  // how a short load fills the upper bits
  typedef logic [1:0]  cnt_t;       // outstanding bus transactions

  ////////////////////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////////////////////

  // bus may hold this many requests without a response
  localparam cnt_t LSU_DEPTH = 2'd2;

  // access size, 2'b11 decodes as byte as well
  localparam data_type_t TYPE_WORD = 2'b00;
  localparam data_type_t TYPE_HALF = 2'b01;
  localparam data_type_t TYPE_BYTE = 2'b10;

  // extension of half-word and byte loads
  localparam sign_ext_t EXT_ZERO = 2'b00; // upper bits cleared
  localparam sign_ext_t EXT_SIGN = 2'b01; // upper bits copy the msb
  localparam sign_ext_t EXT_ONES = 2'b10; // upper bits set

  ////////////////////////////////////////////////////////////////////////////
  // grouped signals
  ////////////////////////////////////////////////////////////////////////////

  // one request phase on the data bus
  typedef struct packed {
    word_t addr;  // word aligned in the second misaligned phase
    logic  we;    // 1 for a store
    be_t   be;    // active byte lanes
    word_t wdata; // store data, already rotated into its lanes
  } lsu_bus_req_t;

  // what a load needs to remember until its response arrives
  typedef struct packed {
    data_type_t data_type; // size of the access
    byte_off_t  offset;    // low address bits of the access
    sign_ext_t  sign_ext;  // fill code for short loads
    logic       we;        // stores return no data
  } lsu_wb_ctrl_t;

  // word 32, we 1, be 4, wdata 32 -> 69 bits per request
  // type 2, offset 2, ext 2, we 1 -> 7 bits per wb entry

endpackage

`default_nettype wire

//--- lsu_datapath/lsu_store_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
  input  logic                 [31:0] addr_i,        // effective address
  input  lsu_pkg::data_type_t         data_type_i,
  input  lsu_pkg::byte_off_t          reg_offset_i,  // where the data sits in the register
  input  lsu_pkg::word_t              wdata_i,
  input  logic                        we_i,
  input  logic                        req_i,
  input  logic                        misaligned_ex_i, // second phase of a split access
  output lsu_pkg::lsu_bus_req_t       bus_req_o,
  output logic                        misaligned_o     // first phase needs a second one
);

  import lsu_pkg::*;

  byte_off_t addr_off;     // byte position of the access
  byte_off_t wdata_off;    // rotation amount for store data
  be_t       be;
  word_t     wdata_rot;

  assign addr_off = addr_i[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    be = 4'b0000;
    case (data_type_i)
      TYPE_WORD: begin
        if (!misaligned_ex_i) begin
          be = 4'b1111 << addr_off;   // upper lanes from the offset on
        end else begin
          be = 4'b1111 >> (3'd4 - {1'b0, addr_off}); // lanes left over for the next word
        end
      end
      TYPE_HALF: begin
        if (!misaligned_ex_i) begin
          be = (addr_off == 2'd3) ? 4'b1000 : (4'b0011 << addr_off);
        end else begin
          be = 4'b0001;               // only offset 3 splits, one byte remains
        end
      end
      TYPE_BYTE, 2'b11: begin         // both upper codes are byte
        be = 4'b0001 << addr_off;
      end
      default: be = 4'b0000;
    endcase
  end

  // store data lands in the lane of the address, taken from the lane of the register
  assign wdata_off = addr_off - reg_offset_i;

  always_comb begin
    case (wdata_off)
      2'd0:    wdata_rot = wdata_i;
      2'd1:    wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_rot = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // misalignment
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    misaligned_o = 1'b0;
    if (req_i && !misaligned_ex_i) begin
      if (data_type_i == TYPE_WORD && addr_off != 2'd0) misaligned_o = 1'b1;
      if (data_type_i == TYPE_HALF && addr_off == 2'd3) misaligned_o = 1'b1;
    end
  end

  // second phase always starts at lane 0 of the next word
  assign bus_req_o.addr  = misaligned_ex_i ? {addr_i[31:2], 2'b00} : addr_i;
  assign bus_req_o.we    = we_i;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

endmodule

`default_nettype wire

//--- lsu_datapath/lsu_load_extend.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extend (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ctrl_update_i, // ex hands its access to wb
  input  lsu_pkg::lsu_wb_ctrl_t wb_ctrl_i,
  input  logic                  rvalid_i,      // response from the bus
  input  lsu_pkg::word_t        rdata_i,
  input  logic                  misaligned_i,  // some phase of a split access is active
  output lsu_pkg::word_t        rdata_o        // load result to the register file
);

  import lsu_pkg::*;

  lsu_wb_ctrl_t wb_q;     // control of the access now waiting for data
  word_t        rdata_q;  // first half of a split load, else last result
  word_t        rdata_w;  // word result, joined for split words
  logic [15:0]  half_sel; // selected half-word before extension
  logic [7:0]   byte_sel; // selected byte before extension
  word_t        rdata_ext;

  // fill the upper bits of a half-word or byte by the extension code
  function automatic word_t extend(input logic [15:0] val, input logic is_half,
                                   input sign_ext_t code);
    logic msb;
    logic fill;
    msb = is_half ? val[15] : val[7];
    case (code)
      EXT_ZERO: fill = 1'b0;
      EXT_ONES: fill = 1'b1;
      EXT_SIGN: fill = msb;
      default:  fill = msb;   // spare code behaves like sign
    endcase
    return is_half ? {{16{fill}}, val} : {{24{fill}}, val[7:0]};
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (ctrl_update_i) begin
      wb_q <= wb_ctrl_i;     // request accepted, wait for rvalid in wb
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////////////////////

  // split words take their low bytes from the held first response
  always_comb begin
    case (wb_q.offset)
      2'd0:    rdata_w = rdata_i;
      2'd1:    rdata_w = {rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w = {rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (wb_q.offset)
      2'd0:    half_sel = rdata_i[15:0];
      2'd1:    half_sel = rdata_i[23:8];
      2'd2:    half_sel = rdata_i[31:16];
      default: half_sel = {rdata_i[7:0], rdata_q[31:24]}; // crosses the word boundary
    endcase
  end

  assign byte_sel = rdata_i[{wb_q.offset, 3'b000} +: 8];

  always_comb begin
    case (wb_q.data_type)
      TYPE_WORD:        rdata_ext = rdata_w;
      TYPE_HALF:        rdata_ext = extend(half_sel, 1'b1, wb_q.sign_ext);
      TYPE_BYTE, 2'b11: rdata_ext = extend({8'h00, byte_sel}, 1'b0, wb_q.sign_ext);
      default:          rdata_ext = rdata_w;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // hold register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rvalid_i && !wb_q.we) begin
      if (misaligned_i) begin
        rdata_q <= rdata_i;    // raw first half, joined on the next response
      end else begin
        rdata_q <= rdata_ext;  // keep the final value for a stalled wb
      end
    end
  end

  // live on the response cycle, held afterwards
  assign rdata_o = rvalid_i ? rdata_ext : rdata_q;

endmodule

`default_nettype wire

//--- src/lsu_trans_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_trans_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic req_i,         // ex stage request
  input  logic gnt_i,         // bus accepted the request
  input  logic rvalid_i,      // bus response for the oldest request
  output logic trans_valid_o, // drive the request onto the bus
  output logic ctrl_update_o, // wb registers take the ex control
  output logic ready_ex_o,    // ex may advance
  output logic ready_wb_o,    // wb may advance
  output logic busy_o         // something in flight or about to be
);

  import lsu_pkg::*;

  cnt_t cnt_q;      // outstanding transactions
  cnt_t cnt_d;
  logic count_up;   // accepted request this cycle
  logic count_down; // response this cycle

  // only issue while the bus has room, no path from rvalid to request
  assign trans_valid_o = req_i && (cnt_q < LSU_DEPTH);

  assign count_up   = trans_valid_o && gnt_i;
  assign count_down = rvalid_i;

  always_comb begin
    unique case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;   // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ready signals
  ////////////////////////////////////////////////////////////////////////////

  // wb is free when empty, otherwise when its response shows up
  assign ready_wb_o = (cnt_q == '0) ? 1'b1 : rvalid_i;

  // ex moves once its request is accepted and wb can follow in lock step
  always_comb begin
    if (!req_i) begin
      ready_ex_o = 1'b1;                // nothing to hand over
    end else if (cnt_q == 2'd0) begin
      ready_ex_o = count_up;            // wb empty, accept is enough
    end else if (cnt_q == 2'd1) begin
      ready_ex_o = count_up && rvalid_i; // wb drains as ex enters
    end else begin
      ready_ex_o = rvalid_i;            // full, no new accept possible
    end
  end

  assign ctrl_update_o = ready_ex_o && req_i;

  assign busy_o = (cnt_q != '0) || trans_valid_o;

endmodule

`default_nettype wire

//--- src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // ex stage
  input  logic                   data_req_ex_i,        // ex wants a load or store
  input  logic                   data_we_ex_i,         // 1 for store
  input  lsu_pkg::data_type_t    data_type_ex_i,       // word, half-word or byte
  input  lsu_pkg::sign_ext_t     data_sign_ext_ex_i,   // fill code for short loads
  input  lsu_pkg::word_t         data_wdata_ex_i,      // store data from the rf
  input  lsu_pkg::byte_off_t     data_reg_offset_ex_i, // byte offset inside the register
  input  lsu_pkg::word_t         operand_a_ex_i,       // base
  input  lsu_pkg::word_t         operand_b_ex_i,       // offset
  input  logic                   addr_useincr_ex_i,    // a + b, else just a
  input  logic                   data_misaligned_ex_i, // second phase of a split access

  // back to ex and the controller
  output lsu_pkg::word_t         data_rdata_ex_o,
  output logic                   data_misaligned_o,
  output logic                   lsu_ready_ex_o,
  output logic                   lsu_ready_wb_o,
  output logic                   busy_o,

  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  output lsu_pkg::word_t         data_addr_o,
  output logic                   data_we_o,
  output lsu_pkg::be_t           data_be_o,
  output lsu_pkg::word_t         data_wdata_o,
  input  logic                   data_rvalid_i,
  input  lsu_pkg::word_t         data_rdata_i
);

  import lsu_pkg::*;

  word_t        addr_eff;    // effective address before phase alignment
  lsu_bus_req_t bus_req;     // request fields built by the store path
  lsu_wb_ctrl_t wb_ctrl;     // what the wb registers take on update
  logic         trans_valid; // request may go out this cycle
  logic         ctrl_update; // ex moves into wb

  // address generation
  assign addr_eff = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;

  assign wb_ctrl = '{
    data_type: data_type_ex_i,
    offset:    addr_eff[1:0],
    sign_ext:  data_sign_ext_ex_i,
    we:        data_we_ex_i
  };

  lsu_store_align u_store_align (
    .addr_i          (addr_eff),
    .data_type_i     (data_type_ex_i),
    .reg_offset_i    (data_reg_offset_ex_i),
    .wdata_i         (data_wdata_ex_i),
    .we_i            (data_we_ex_i),
    .req_i           (data_req_ex_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .bus_req_o       (bus_req),
    .misaligned_o    (data_misaligned_o)
  );

  lsu_trans_ctrl u_trans_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (data_req_ex_i),
    .gnt_i         (data_gnt_i),       // grant is the accept
    .rvalid_i      (data_rvalid_i),
    .trans_valid_o (trans_valid),
    .ctrl_update_o (ctrl_update),
    .ready_ex_o    (lsu_ready_ex_o),
    .ready_wb_o    (lsu_ready_wb_o),
    .busy_o        (busy_o)
  );

  lsu_load_extend u_load_extend (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_update_i (ctrl_update),
    .wb_ctrl_i     (wb_ctrl),
    .rvalid_i      (data_rvalid_i),
    .rdata_i       (data_rdata_i),
    .misaligned_i  (data_misaligned_ex_i | data_misaligned_o), // either phase of a split
    .rdata_o       (data_rdata_ex_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // bus side, fields stay stable while trans_valid waits for grant
  ////////////////////////////////////////////////////////////////////////////

  assign data_req_o   = trans_valid;
  assign data_addr_o  = bus_req.addr;
  assign data_we_o    = bus_req.we;
  assign data_be_o    = bus_req.be;
  assign data_wdata_o = bus_req.wdata;

endmodule

`default_nettype wire

//--- verification/lsu_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_clk_gen (
  output logic clk_o,   // 40 ns period
  output logic rst_n_o  // active low, released after 16 rising edges
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o; // half period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;            // release away from any async edge
  end

endmodule

`default_nettype wire

//--- verification/lsu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_sva (
  input logic           clk,
  input logic           rst_n,
  input logic           data_req_o,
  input logic           data_gnt_i,
  input logic           data_we_o,
  input lsu_pkg::be_t   data_be_o,
  input lsu_pkg::word_t data_addr_o,
  input lsu_pkg::word_t data_wdata_o,
  input logic           data_rvalid_i
);

  import lsu_pkg::*;

  logic [2:0] pend_q; // accepted requests still waiting for rvalid
  logic       accept;
  int         fail_cnt = 0; // failed assertions, read by the testbench

  assign accept = data_req_o && data_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else if (accept && !data_rvalid_i) begin
      pend_q <= pend_q + 3'd1;
    end else if (!accept && data_rvalid_i) begin
      pend_q <= pend_q - 3'd1;
    end
  end

  // never more in flight than the bus depth
  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
    pend_q <= {1'b0, LSU_DEPTH})
    else begin
      $error("more outstanding transactions than the depth allows");
      fail_cnt++;
    end

  // a response needs an accepted request
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (pend_q != 3'd0))
    else begin
      $error("rvalid without an outstanding request");
      fail_cnt++;
    end

  a_req_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(data_req_o)
      && (!data_req_o || !$isunknown({data_addr_o, data_be_o, data_we_o})))
    else begin
      $error("request phase carries unknown bits");
      fail_cnt++;
    end

  // waiting for grant keeps the request and its fields
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) && $stable(data_be_o)
      && $stable(data_we_o) && $stable(data_wdata_o))
    else begin
      $error("request changed before grant");
      fail_cnt++;
    end

endmodule

bind lsu_top lsu_sva u_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .data_req_o    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_we_o     (data_we_o),
  .data_be_o     (data_be_o),
  .data_addr_o   (data_addr_o),
  .data_wdata_o  (data_wdata_o),
  .data_rvalid_i (data_rvalid_i)
);

`default_nettype wire

//--- verification/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  import lsu_pkg::*;

  typedef struct packed {
    logic [3:0] op;        // 0 store, 1 load, 2 two pipelined loads
    data_type_t dtype;
    sign_ext_t  ext;
    word_t      opa;
    word_t      opb;
    logic       incr;
    byte_off_t  roff;
    word_t      wdata;
    word_t      mem0;      // first response
    word_t      mem1;      // second response
    be_t        be0;
    be_t        be1;
    word_t      exp_wdata; // second load result for op 2
    word_t      exp_rdata;
    logic       mis;
    logic [7:0] gdel;      // ff random
    logic [7:0] rdel;
  } test_t;

  logic clk, rst_n;
  logic data_req_ex_i, data_we_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  data_type_t data_type_ex_i;
  sign_ext_t  data_sign_ext_ex_i;
  byte_off_t  data_reg_offset_ex_i;
  word_t data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i, data_rdata_ex_o;
  logic data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;
  logic data_req_o, data_we_o;
  logic data_gnt_i = 1'b0;
  logic data_rvalid_i = 1'b0;
  word_t data_rdata_i = '0;
  word_t data_addr_o, data_wdata_o;
  be_t data_be_o;

  test_t tests[$];
  int    seed = 62657;
  int    err_cnt = 0;
  int    cycles = 0;
  int    limit = 0;
  // bus model state
  int    gd = 0, bus_cyc = 0, last_due = 0, n_accept = 0, outstanding = 0, max_out = 0;
  logic [7:0] gdel_cfg = 8'hff, rdel_cfg = 8'hff;
  word_t mem_words[2];
  word_t resp_data[$], acc_addr[$], acc_wdata[$], rd_got[$];
  int    resp_due[$];
  be_t   acc_be[$];
  logic  acc_we[$];

  lsu_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top lsu_top_i (.*);

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic int pick_delay(input logic [7:0] cfg);
    if (cfg == 8'hff) return $unsigned($random(seed)) % 3;
    return int'(cfg);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus model: grant after 0..2 cycles, rvalid 1..3 cycles after accept
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : bus_model
    int due;
    bus_cyc++;
    data_rvalid_i <= 1'b0;
    if (rst_n) begin
      if (resp_due.size() != 0) check("busy_o", busy_o, 1'b1); // work still in flight
      if (data_rvalid_i) begin
        rd_got.push_back(data_rdata_ex_o); // live result in the rvalid cycle
        outstanding--;
      end
      if (data_req_o && data_gnt_i) begin
        acc_addr.push_back(data_addr_o);
        acc_be.push_back(data_be_o);
        acc_we.push_back(data_we_o);
        acc_wdata.push_back(data_wdata_o);
        resp_data.push_back(n_accept < 2 ? mem_words[n_accept] : 32'h0);
        n_accept++;
        due = bus_cyc + pick_delay(rdel_cfg);
        if (due <= last_due) due = last_due + 1; // keep responses in order
        last_due = due;
        resp_due.push_back(due);
        outstanding++;
        if (outstanding > max_out) max_out = outstanding;
        gd = pick_delay(gdel_cfg);
      end else if (data_req_o) begin
        if (gd > 0) gd--;
      end else begin
        gd = pick_delay(gdel_cfg);
      end
      data_gnt_i <= (gd == 0);
      if (resp_due.size() != 0 && resp_due[0] <= bus_cyc) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= resp_data.pop_front();
        void'(resp_due.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, the DUT did not finish its accesses", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // drive one access and hold it until the LSU lets EX move on
  task automatic issue(input test_t tc, input logic phase2, input word_t a, output logic mis);
    word_t ref_addr, ref_wdata;
    be_t   ref_be;
    logic  first;
    logic  done;
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= (tc.op == 4'd0);
    data_type_ex_i       <= tc.dtype;
    data_sign_ext_ex_i   <= tc.ext;
    data_wdata_ex_i      <= tc.wdata;
    data_reg_offset_ex_i <= tc.roff;
    operand_a_ex_i       <= a;
    operand_b_ex_i       <= tc.opb;
    addr_useincr_ex_i    <= tc.incr;
    data_misaligned_ex_i <= phase2;
    mis = 1'b0;
    first = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (data_misaligned_o) mis = 1'b1;
      if (data_req_o && first) begin
        ref_addr  = data_addr_o;
        ref_be    = data_be_o;
        ref_wdata = data_wdata_o;
        first = 1'b0;
      end else if (data_req_o) begin // fields frozen while waiting for grant
        check("data_addr_o", data_addr_o, ref_addr);
        check("data_be_o", {28'h0, data_be_o}, {28'h0, ref_be});
        check("data_wdata_o", data_wdata_o, ref_wdata);
      end
      if (data_req_o && !data_gnt_i) check("lsu_ready_ex_o", lsu_ready_ex_o, 1'b0);
      done = lsu_ready_ex_o;
    end
  endtask

  task automatic run_test(input int idx, input test_t tc);
    int    errs0;
    int    exp_acc;
    word_t eff;
    logic  mis;
    logic  dummy;
    errs0 = err_cnt;
    n_accept = 0;
    max_out = 0;
    acc_addr.delete();
    acc_be.delete();
    acc_we.delete();
    acc_wdata.delete();
    rd_got.delete();
    mem_words[0] = tc.mem0;
    mem_words[1] = tc.mem1;
    gdel_cfg = tc.gdel;
    rdel_cfg = tc.rdel;
    eff = tc.incr ? tc.opa + tc.opb : tc.opa;
    @(posedge clk); // idle edge, the bus model picks its grant delay from the new setting
    issue(tc, 1'b0, tc.opa, mis);
    if (tc.op == 4'd2) issue(tc, 1'b0, tc.opa + 32'd4, dummy); // back-to-back
    else if (mis) issue(tc, 1'b1, tc.opa + 32'd4, dummy);      // controller replays
    data_req_ex_i        <= 1'b0;
    data_misaligned_ex_i <= 1'b0;
    do @(posedge clk); while (busy_o || resp_due.size() != 0 || data_rvalid_i);
    exp_acc = (tc.op == 4'd2 || tc.mis) ? 2 : 1;
    check("accepted requests", n_accept, exp_acc);
    if (tc.op != 4'd2) check("data_misaligned_o", mis, tc.mis);
    if (n_accept == exp_acc) begin
      check("data_addr_o", acc_addr[0], eff);
      check("data_be_o", {28'h0, acc_be[0]}, {28'h0, tc.be0});
      check("data_we_o", acc_we[0], tc.op == 4'd0);
      if (tc.op == 4'd0) check("data_wdata_o", acc_wdata[0], tc.exp_wdata);
      if (exp_acc == 2) begin
        // second phase starts at lane 0 of the next word
        check("data_addr_o", acc_addr[1], tc.op == 4'd2 ? eff + 32'd4 : (eff + 32'd4) & ~32'd3);
        check("data_be_o", {28'h0, acc_be[1]}, {28'h0, tc.be1});
        check("data_we_o", acc_we[1], tc.op == 4'd0);
        if (tc.op == 4'd0) check("data_wdata_o", acc_wdata[1], tc.exp_wdata);
      end
    end
    if (tc.op != 4'd0 && rd_got.size() == exp_acc) begin
      if (tc.op == 4'd2) begin
        check("data_rdata_ex_o", rd_got[0], tc.exp_rdata);
        check("data_rdata_ex_o", rd_got[1], tc.exp_wdata);
        check("outstanding", max_out, 2);
      end else begin
        check("data_rdata_ex_o", rd_got[exp_acc-1], tc.exp_rdata);
      end
    end else if (tc.op != 4'd0) begin
      check("responses", rd_got.size(), exp_acc);
    end
    $display("test %0d op %0d addr %h: %s", idx, tc.op, eff, err_cnt == errs0 ? "ok" : "failed");
  endtask

  initial begin
    int          fd, n, failed;
    int          sva_fails;
    string       line;
    logic [31:0] v [17];
    test_t       tc;
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = TYPE_WORD;
    data_sign_ext_ex_i = EXT_ZERO;
    data_wdata_ex_i = '0;
    data_reg_offset_ex_i = '0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    addr_useincr_ex_i = 1'b0;
    data_misaligned_ex_i = 1'b0;
    failed = 0;
    fd = $fopen("verification/lsu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test vector file");
      $display("TEST FAILED");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() == 0 || line[0] == "#") continue;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                    v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
        if (n != 17) continue; // blank line
        tc = '{v[0][3:0], v[1][1:0], v[2][1:0], v[3], v[4], v[5][0], v[6][1:0], v[7],
               v[8], v[9], v[10][3:0], v[11][3:0], v[12], v[13], v[14][0], v[15][7:0],
               v[16][7:0]};
        tests.push_back(tc);
      end
      $fclose(fd);
      limit = 40 * tests.size() + 40; // reset phase on top
      wait (rst_n);
      @(posedge clk);
      check("busy_o", busy_o, 1'b0);
      check("lsu_ready_ex_o", lsu_ready_ex_o, 1'b1);
      check("lsu_ready_wb_o", lsu_ready_wb_o, 1'b1);
      $display("reset state: %s", err_cnt == 0 ? "ok" : "failed");
      for (int i = 0; i < tests.size(); i++) begin
        n = err_cnt;
        run_test(i, tests[i]);
        if (err_cnt != n) failed++;
      end
      sva_fails = lsu_top_i.u_sva.fail_cnt;
      $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
               tests.size(), failed, err_cnt, sva_fails);
      if (err_cnt == 0 && sva_fails == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verification/lsu_tests.txt
# op typ ext opa opb inc roff wdata mem0 mem1 be0 be1 exp_wdata exp_rdata mis gdel rdel
# op 0 store, 1 load, 2 two pipelined word loads (exp_wdata column holds the second result)
# all hex, gdel/rdel ff picks a random delay, other values fix it
0 0 0 00001000 00000000 0 0 11223344 0 0 f 0 11223344 0 0 ff ff
0 1 0 00001000 00000000 0 0 11223344 0 0 3 0 11223344 0 0 ff ff
0 1 0 00001000 00000002 1 0 11223344 0 0 c 0 33441122 0 0 ff ff
0 1 0 00001000 00000001 1 0 11223344 0 0 6 0 22334411 0 0 ff ff
0 1 0 00001002 00000000 0 2 11223344 0 0 c 0 11223344 0 0 ff ff
0 2 0 00001000 00000001 1 0 11223344 0 0 2 0 22334411 0 0 ff ff
0 2 0 00001003 00000000 0 0 11223344 0 0 8 0 44112233 0 0 ff ff
0 2 0 00001000 00000002 1 1 11223344 0 0 4 0 22334411 0 0 ff ff
0 3 0 00001000 00000000 1 0 11223344 0 0 1 0 11223344 0 0 ff ff
0 0 0 00002000 00000055 0 0 a5a5c3c3 0 0 f 0 a5a5c3c3 0 0 ff ff
1 0 0 00001000 00000000 0 0 0 80ff7f01 0 f 0 0 80ff7f01 0 ff ff
1 1 0 00001000 00000000 0 0 0 80ff7f01 0 3 0 0 00007f01 0 ff ff
1 1 1 00001000 00000000 0 0 0 80ff7f01 0 3 0 0 00007f01 0 ff ff
1 1 2 00001000 00000000 0 0 0 80ff7f01 0 3 0 0 ffff7f01 0 ff ff
1 1 1 00001002 00000000 0 0 0 80ff7f01 0 c 0 0 ffff80ff 0 ff ff
1 1 0 00001002 00000000 0 0 0 80ff7f01 0 c 0 0 000080ff 0 ff ff
1 1 1 00001001 00000000 0 0 0 80ff7f01 0 6 0 0 ffffff7f 0 ff ff
1 2 2 00001000 00000000 0 0 0 80ff7f01 0 1 0 0 ffffff01 0 ff ff
1 2 1 00001001 00000000 0 0 0 80ff7f01 0 2 0 0 0000007f 0 ff ff
1 2 1 00000ffe 00000004 1 0 0 80ff7f01 0 4 0 0 ffffffff 0 ff ff
1 2 0 00001003 00000000 0 0 0 80ff7f01 0 8 0 0 00000080 0 ff ff
1 3 1 00001003 00000000 0 0 0 80ff7f01 0 8 0 0 ffffff80 0 ff ff
1 0 0 00001001 00000000 0 0 0 44332211 88776655 e 1 0 55443322 1 ff ff
1 0 0 00001002 00000000 0 0 0 44332211 88776655 c 3 0 66554433 1 ff ff
1 0 0 00001003 00000000 0 0 0 44332211 88776655 8 7 0 77665544 1 ff ff
1 1 1 00001003 00000000 0 0 0 44332211 88776695 8 1 0 ffff9544 1 ff ff
0 0 0 00001002 00000000 0 0 11223344 0 0 c 3 33441122 0 1 ff ff
0 1 0 00001003 00000000 0 0 11223344 0 0 8 1 44112233 0 1 ff ff
# grant held back
1 0 0 00001000 00000000 0 0 0 13579bdf 0 f 0 0 13579bdf 0 3 2
0 2 0 00001001 00000001 1 0 000000a5 0 0 4 0 00a50000 0 2 2
1 0 0 00001002 00000000 0 0 0 44332211 88776655 c 3 0 66554433 1 2 0
# two loads in flight
2 0 0 00003000 00000000 0 0 0 0badf00d cafe1234 f f cafe1234 0badf00d 0 0 2

//--- src.f
common/lsu_pkg.sv
lsu_datapath/lsu_store_align.sv
lsu_datapath/lsu_load_extend.sv
src/lsu_trans_ctrl.sv
src/lsu_top.sv
verification/lsu_clk_gen.sv
verification/lsu_sva.sv
verification/lsu_tb.sv

//--- Makefile
# Verilator build for the load/store unit testbench
# usage: make compile | make run | make clean

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SRCS      := $(shell cat $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the pass message in the simulation output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
